//--- hw/conv_pkg.sv
// ********************
// shared widths, lane and line types,
// the cache-line union and the request,
// response and job structs
// ********************
`default_nettype none

package conv_pkg;

  localparam int ADDR_W = 58;
  localparam int TAG_W  = 14;
  localparam int LINE_W = 512;
  localparam int LANES  = 8;

  typedef logic signed [31:0] part_t;

  // re sits in the low half
  typedef struct packed {
    part_t im;
    part_t re;
  } lane_t;

  // lane j occupies bits 64j upward
  typedef union packed {
    logic [LINE_W-1:0]    raw;
    lane_t [LANES-1:0]    lanes;
  } line_u;

  typedef enum logic {
    kind_image  = 1'b0,
    kind_kernel = 1'b1
  } line_kind_e;

  typedef struct packed {
    logic [TAG_W-2:0] slot;
    line_kind_e       kind;
  } rd_tag_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    rd_tag_t           tag;
  } rd_req_t;

  typedef struct packed {
    logic    valid;
    rd_tag_t tag;
    line_u   data;
  } rd_rsp_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    line_u             data;
  } wr_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] image_base;
    logic [ADDR_W-1:0] kernel_base;
    logic [ADDR_W-1:0] dest_base;
    logic [31:0]       num_lines;
  } job_t;

endpackage

`default_nettype wire

//--- hw/fetch_sequencer.sv
// ********************
// read request sequencer, paired image
// and kernel fetches under a credit limit
// ********************
`default_nettype none

module fetch_sequencer #(
  parameter int SLOTS = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  conv_pkg::job_t              job,
  input  logic                        rd_req_almostfull,
  input  logic                        pop,
  output logic [conv_pkg::ADDR_W-1:0] dest_base,
  output logic [31:0]                 num_lines,
  output conv_pkg::rd_req_t           rd_req
);

  localparam int IDX_W        = $clog2(SLOTS);
  localparam int SLOT_FIELD_W = conv_pkg::TAG_W - 1;
  localparam int AW           = conv_pkg::ADDR_W;

  typedef enum logic {
    st_idle,
    st_issue
  } state_e;

  state_e               state;
  conv_pkg::job_t       job_q;
  conv_pkg::line_kind_e next_kind;
  logic [31:0]          line_cnt;
  logic [31:0]          retired_cnt;
  logic [IDX_W-1:0]     slot_cnt;
  logic                 credit_ok;

  assign dest_base = job_q.dest_base;
  assign num_lines = job_q.num_lines;

  // lines started but not yet popped by the combiner
  assign credit_ok = (line_cnt - retired_cnt) < 32'(SLOTS);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_idle;
      next_kind   <= conv_pkg::kind_image;
      line_cnt    <= '0;
      retired_cnt <= '0;
      slot_cnt    <= '0;
      rd_req.en   <= 1'b0;
    end else begin
      rd_req.en <= 1'b0;
      if (pop) begin
        retired_cnt <= retired_cnt + 32'd1;
      end
      if (start) begin
        job_q       <= job;
        state       <= st_issue;
        next_kind   <= conv_pkg::kind_image;
        line_cnt    <= '0;
        retired_cnt <= '0;
      end else if (state == st_issue && !rd_req_almostfull) begin
        if (next_kind == conv_pkg::kind_kernel) begin
          // second half of a started line, no credit needed
          rd_req.en       <= 1'b1;
          rd_req.addr     <= job_q.kernel_base + AW'(line_cnt);
          rd_req.tag.slot <= SLOT_FIELD_W'(slot_cnt);
          rd_req.tag.kind <= conv_pkg::kind_kernel;
          next_kind       <= conv_pkg::kind_image;
          line_cnt        <= line_cnt + 32'd1;
          // slot numbering runs on across jobs to stay in step with the head
          slot_cnt        <= slot_cnt + 1'b1;
        end else if (line_cnt == job_q.num_lines) begin
          state <= st_idle;
        end else if (credit_ok) begin
          rd_req.en       <= 1'b1;
          rd_req.addr     <= job_q.image_base + AW'(line_cnt);
          rd_req.tag.slot <= SLOT_FIELD_W'(slot_cnt);
          rd_req.tag.kind <= conv_pkg::kind_image;
          next_kind       <= conv_pkg::kind_kernel;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/line_store.sv
// ********************
// slot memory for one line kind,
// filled from tagged read responses
// ********************
`default_nettype none

module line_store #(
  parameter int                   SLOTS = 16,
  parameter conv_pkg::line_kind_e KIND  = conv_pkg::kind_image
) (
  input  logic                     clk,
  input  logic                     reset,
  input  conv_pkg::rd_rsp_t        rd_rsp,
  input  logic [$clog2(SLOTS)-1:0] head_slot,
  input  logic                     pop,
  output logic                     head_full,
  output conv_pkg::line_u          head_line
);

  localparam int IDX_W = $clog2(SLOTS);

  logic [conv_pkg::LINE_W-1:0] mem [SLOTS];
  logic [SLOTS-1:0]            full;
  logic                        hit;
  logic [IDX_W-1:0]            wr_slot;

  // only responses of our own kind land here
  assign hit     = rd_rsp.valid && (rd_rsp.tag.kind == KIND);
  assign wr_slot = rd_rsp.tag.slot[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (hit) begin
      mem[wr_slot] <= rd_rsp.data.raw;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= '0;
    end else begin
      if (pop) begin
        full[head_slot] <= 1'b0;
      end
      if (hit) begin
        full[wr_slot] <= 1'b1;
      end
    end
  end

  assign head_full = full[head_slot];

  always_comb begin
    head_line.raw = mem[head_slot];
  end

endmodule

`default_nettype wire

//--- hw/lane_combiner.sv
// ********************
// head-index pairing and two-stage
// lane-wise complex multiply
// ********************
`default_nettype none

module lane_combiner #(
  parameter int SLOTS = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     image_full,
  input  logic                     kernel_full,
  input  conv_pkg::line_u          image_line,
  input  conv_pkg::line_u          kernel_line,
  input  logic                     space,
  output logic [$clog2(SLOTS)-1:0] head_slot,
  output logic                     pop,
  output logic                     prod_valid,
  output conv_pkg::line_u          prod_line
);

  localparam int LANES = conv_pkg::LANES;

  // stage one partial products, low 32 bits kept
  conv_pkg::part_t rr [LANES];
  conv_pkg::part_t ii [LANES];
  conv_pkg::part_t ri [LANES];
  conv_pkg::part_t ir [LANES];
  logic            s1_valid;

  // both lines of the oldest index present and room downstream
  assign pop = image_full && kernel_full && space;

  always_ff @(posedge clk) begin
    if (reset) begin
      head_slot  <= '0;
      s1_valid   <= 1'b0;
      prod_valid <= 1'b0;
    end else begin
      if (pop) begin
        head_slot <= head_slot + 1'b1;
      end
      s1_valid   <= pop;
      prod_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      for (int j = 0; j < LANES; j++) begin
        rr[j] <= image_line.lanes[j].re * kernel_line.lanes[j].re;
        ii[j] <= image_line.lanes[j].im * kernel_line.lanes[j].im;
        ri[j] <= image_line.lanes[j].re * kernel_line.lanes[j].im;
        ir[j] <= image_line.lanes[j].im * kernel_line.lanes[j].re;
      end
    end
  end

  // stage two, (ar*br - ai*bi) + j(ar*bi + ai*br)
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      for (int j = 0; j < LANES; j++) begin
        prod_line.lanes[j].re <= rr[j] - ii[j];
        prod_line.lanes[j].im <= ri[j] + ir[j];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/write_queue.sv
// ********************
// output FIFO, write requests to
// consecutive lines and done flag
// ********************
`default_nettype none

module write_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  logic [conv_pkg::ADDR_W-1:0] dest_base,
  input  logic [31:0]                 num_lines,
  input  logic                        prod_valid,
  input  conv_pkg::line_u             prod_line,
  input  logic                        wr_req_almostfull,
  output logic                        space,
  output conv_pkg::wr_req_t           wr_req,
  output logic                        done
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int AW    = conv_pkg::ADDR_W;

  logic [conv_pkg::LINE_W-1:0] mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            count;
  logic [31:0]                 wr_idx;
  logic                        running;
  logic                        drain;

  // three free entries cover the two products still in the multiplier
  assign space = (32'(count) + 32'd3) <= 32'(QUEUE_DEPTH);
  assign drain = (count != '0) && !wr_req_almostfull;

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      mem[wr_ptr] <= prod_line.raw;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      wr_idx    <= '0;
      running   <= 1'b0;
      done      <= 1'b0;
      wr_req.en <= 1'b0;
    end else begin
      if (prod_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      count     <= count + CNT_W'(prod_valid) - CNT_W'(drain);
      wr_req.en <= drain;
      if (drain) begin
        rd_ptr          <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        wr_req.data.raw <= mem[rd_ptr];
        wr_req.addr     <= dest_base + AW'(wr_idx);
      end
      if (start) begin
        wr_idx  <= '0;
        running <= 1'b1;
        done    <= 1'b0;
      end else begin
        if (drain) begin
          wr_idx <= wr_idx + 32'd1;
        end
        // wr_idx reaches num_lines in the cycle of the last write
        if (running && wr_idx == num_lines) begin
          done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/conv_stream_top.sv
// ********************
// top level, sequencer, two line
// stores, combiner and write queue
// ********************
`default_nettype none

module conv_stream_top #(
  parameter int SLOTS       = 16,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  conv_pkg::job_t    job,
  input  conv_pkg::rd_rsp_t rd_rsp,
  input  logic              rd_req_almostfull,
  input  logic              wr_req_almostfull,
  output conv_pkg::rd_req_t rd_req,
  output conv_pkg::wr_req_t wr_req,
  output logic              done
);

  logic [conv_pkg::ADDR_W-1:0] dest_base;
  logic [31:0]                 num_lines;
  logic [$clog2(SLOTS)-1:0]    head_slot;
  logic                        pop;
  logic                        space;
  logic                        image_full;
  logic                        kernel_full;
  conv_pkg::line_u             image_line;
  conv_pkg::line_u             kernel_line;
  logic                        prod_valid;
  conv_pkg::line_u             prod_line;

  fetch_sequencer #(.SLOTS(SLOTS)) sequencer (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .job               (job),
    .rd_req_almostfull (rd_req_almostfull),
    .pop               (pop),
    .dest_base         (dest_base),
    .num_lines         (num_lines),
    .rd_req            (rd_req)
  );

  line_store #(.SLOTS(SLOTS), .KIND(conv_pkg::kind_image)) image_store (
    .clk       (clk),
    .reset     (reset),
    .rd_rsp    (rd_rsp),
    .head_slot (head_slot),
    .pop       (pop),
    .head_full (image_full),
    .head_line (image_line)
  );

  line_store #(.SLOTS(SLOTS), .KIND(conv_pkg::kind_kernel)) kernel_store (
    .clk       (clk),
    .reset     (reset),
    .rd_rsp    (rd_rsp),
    .head_slot (head_slot),
    .pop       (pop),
    .head_full (kernel_full),
    .head_line (kernel_line)
  );

  lane_combiner #(.SLOTS(SLOTS)) combiner (
    .clk         (clk),
    .reset       (reset),
    .image_full  (image_full),
    .kernel_full (kernel_full),
    .image_line  (image_line),
    .kernel_line (kernel_line),
    .space       (space),
    .head_slot   (head_slot),
    .pop         (pop),
    .prod_valid  (prod_valid),
    .prod_line   (prod_line)
  );

  write_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) out_queue (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .dest_base         (dest_base),
    .num_lines         (num_lines),
    .prod_valid        (prod_valid),
    .prod_line         (prod_line),
    .wr_req_almostfull (wr_req_almostfull),
    .space             (space),
    .wr_req            (wr_req),
    .done              (done)
  );

endmodule

`default_nettype wire

//--- bench/mem_model.sv
// ********************
// shared-memory model, random line
// contents, out-of-order read responses
// and random almost-full levels
// ********************
`default_nettype none

module mem_model (
  input  logic              clk,
  input  logic              reset,
  input  conv_pkg::rd_req_t rd_req,
  output conv_pkg::rd_rsp_t rd_rsp,
  output logic              rd_req_almostfull,
  output logic              wr_req_almostfull
);

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0]                 due;
    conv_pkg::rd_tag_t           tag;
    logic [conv_pkg::ADDR_W-1:0] addr;
  } pending_t;

  // line contents, made on the first read of each full address
  logic [conv_pkg::LINE_W-1:0] lines [logic [conv_pkg::ADDR_W-1:0]];
  pending_t                    pending [$];
  int                          seed = 32'heb13;
  int unsigned                 cycle = 0;
  conv_pkg::rd_rsp_t           rsp_q = '0;
  logic                        rd_af_q = 1'b0;
  logic                        wr_af_q = 1'b0;

  assign rd_rsp            = rsp_q;
  assign rd_req_almostfull = rd_af_q;
  assign wr_req_almostfull = wr_af_q;

  always @(posedge clk) begin : serve
    pending_t                    p;
    conv_pkg::rd_rsp_t           r;
    logic [conv_pkg::LINE_W-1:0] fill;
    int                          pick;
    pick = -1;
    r = '0;
    if (reset) begin
      pending.delete();
      rd_af_q <= 1'b0;
      wr_af_q <= 1'b0;
    end else begin
      if (rd_req.en) begin
        if (!lines.exists(rd_req.addr)) begin
          for (int i = 0; i < 16; i++) begin
            fill[32*i +: 32] = $random(seed);
          end
          lines[rd_req.addr] = fill;
        end
        p.addr = rd_req.addr;
        p.tag  = rd_req.tag;
        // answer after 1 to 20 cycles
        p.due  = cycle + 1 + ($unsigned($random(seed)) % 20);
        pending.push_back(p);
      end
      // first ready entry wins, so the order follows the random delays
      foreach (pending[i]) begin
        if (pick < 0 && pending[i].due <= cycle) begin
          pick = i;
        end
      end
      if (pick >= 0) begin
        p = pending[pick];
        pending.delete(pick);
        r.valid    = 1'b1;
        r.tag      = p.tag;
        r.data.raw = lines[p.addr];
      end
      rd_af_q <= ($random(seed) & 3) == 0;
      wr_af_q <= ($random(seed) & 3) == 0;
    end
    rsp_q <= r;
    cycle = cycle + 1;
  end

endmodule

`default_nettype wire

//--- bench/tb_conv_stream.sv
// ********************
// testbench for conv_stream_top
// clock, reset, two jobs, reference
// complex products and all checks
// ********************
`default_nettype none

module tb_conv_stream;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW           = conv_pkg::ADDR_W;
  localparam int SLOTS        = 16;
  localparam int DONE_TIMEOUT = 5000;

  logic              clk;
  logic              reset = 1'b1;
  logic              start = 1'b0;
  conv_pkg::job_t    job = '0;
  conv_pkg::rd_rsp_t rd_rsp;
  logic              rd_req_almostfull;
  logic              wr_req_almostfull;
  conv_pkg::rd_req_t rd_req;
  conv_pkg::wr_req_t wr_req;
  logic              done;

  // monitor state
  conv_pkg::job_t    cur_job = '0;
  bit                job_seen = 1'b0;
  bit                done_seen = 1'b0;
  logic              rd_af_q = 1'b0;
  logic              wr_af_q = 1'b0;
  int                rd_count = 0;
  int                wr_count = 0;
  bit                rd_seen [logic [AW-1:0]];
  bit                wr_seen [logic [AW-1:0]];
  // slot carried by the image read of each line offset
  logic [conv_pkg::TAG_W-2:0] image_slot [logic [AW-1:0]];

  mem_model mem0 (
    .clk               (clk),
    .reset             (reset),
    .rd_req            (rd_req),
    .rd_rsp            (rd_rsp),
    .rd_req_almostfull (rd_req_almostfull),
    .wr_req_almostfull (wr_req_almostfull)
  );

  conv_stream_top #(.SLOTS(SLOTS), .QUEUE_DEPTH(8)) dut0 (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .job               (job),
    .rd_rsp            (rd_rsp),
    .rd_req_almostfull (rd_req_almostfull),
    .wr_req_almostfull (wr_req_almostfull),
    .rd_req            (rd_req),
    .wr_req            (wr_req),
    .done              (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string name, input logic [511:0] exp_val,
                                 input logic [511:0] got_val);
    abort_run($sformatf("ERR t=%0t %s expected %h got %h", $time, name, exp_val, got_val));
  endtask

  // lane j: re in bits 64j, im above it, low 32 bits of each result kept
  function automatic logic [511:0] complex_product(input logic [511:0] a,
                                                   input logic [511:0] b);
    logic [511:0]       r;
    logic signed [31:0] ar;
    logic signed [31:0] ai;
    logic signed [31:0] br;
    logic signed [31:0] bi;
    logic signed [63:0] re;
    logic signed [63:0] im;
    for (int j = 0; j < 8; j++) begin
      ar = a[64*j +: 32];
      ai = a[64*j+32 +: 32];
      br = b[64*j +: 32];
      bi = b[64*j+32 +: 32];
      re = 64'(ar) * 64'(br) - 64'(ai) * 64'(bi);
      im = 64'(ar) * 64'(bi) + 64'(ai) * 64'(br);
      r[64*j +: 32]    = re[31:0];
      r[64*j+32 +: 32] = im[31:0];
    end
    return r;
  endfunction

  always @(posedge clk) begin : monitor
    logic [AW-1:0]  off;
    logic [511:0]   exp_line;
    if (!reset) begin
      if (!job_seen) begin
        assert (!rd_req.en && !wr_req.en && !done)
          else abort_run("request or done active before the first start");
      end
      assert (!(rd_af_q && rd_req.en))
        else abort_run("read request issued after read almost-full was high");
      assert (!(wr_af_q && wr_req.en))
        else abort_run("write request issued after write almost-full was high");
      if (start) begin
        cur_job   = job;
        job_seen  = 1'b1;
        done_seen = 1'b0;
        rd_count  = 0;
        wr_count  = 0;
        rd_seen.delete();
        wr_seen.delete();
        image_slot.delete();
      end else begin
        if (rd_req.en) begin
          if (rd_req.tag.kind == conv_pkg::kind_image) begin
            off = rd_req.addr - cur_job.image_base;
          end else begin
            off = rd_req.addr - cur_job.kernel_base;
          end
          assert (off < AW'(cur_job.num_lines))
            else abort_run($sformatf("read address %h outside the range of its kind",
                                     rd_req.addr));
          assert (!rd_seen.exists(rd_req.addr))
            else abort_run($sformatf("read address %h requested twice", rd_req.addr));
          assert (32'(rd_req.tag.slot) < 32'(SLOTS))
            else abort_run($sformatf("read tag slot %0d beyond the store size",
                                     rd_req.tag.slot));
          if (rd_req.tag.kind == conv_pkg::kind_image) begin
            image_slot[off] = rd_req.tag.slot;
          end else begin
            assert (image_slot.exists(off) && image_slot[off] == rd_req.tag.slot)
              else abort_run($sformatf("kernel read of line %0d not paired with its image slot",
                                       off));
          end
          rd_seen[rd_req.addr] = 1'b1;
          rd_count++;
        end
        if (wr_req.en) begin
          off = wr_req.addr - cur_job.dest_base;
          assert (off < AW'(cur_job.num_lines))
            else abort_run($sformatf("write address %h outside the destination",
                                     wr_req.addr));
          assert (!wr_seen.exists(off))
            else abort_run($sformatf("destination line %0d written twice", off));
          wr_seen[off] = 1'b1;
          exp_line = complex_product(mem0.lines[cur_job.image_base + off],
                                     mem0.lines[cur_job.kernel_base + off]);
          assert (wr_req.data.raw == exp_line)
            else report_mismatch("wr_req.data", exp_line, wr_req.data.raw);
          wr_count++;
        end
        if (done) begin
          assert (wr_count == int'(cur_job.num_lines) &&
                  rd_count == 2 * int'(cur_job.num_lines))
            else abort_run("done raised before all reads and writes of the job");
          done_seen = 1'b1;
        end
        assert (done || !done_seen)
          else abort_run("done dropped before the next start");
      end
    end
    rd_af_q = rd_req_almostfull;
    wr_af_q = wr_req_almostfull;
  end

  task automatic run_job(input conv_pkg::job_t j);
    int waited;
    waited = 0;
    job   <= j;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > DONE_TIMEOUT) begin
        abort_run("timeout, done did not rise");
      end
    end while (!done);
    // a few more cycles so done is seen to hold
    repeat (4) @(posedge clk);
  endtask

  initial begin : main
    conv_pkg::job_t first_job;
    conv_pkg::job_t second_job;
    first_job.image_base   = 58'h0000_1000;
    first_job.kernel_base  = 58'h0000_2000;
    first_job.dest_base    = 58'h0000_3000;
    first_job.num_lines    = 32'd10;
    // more lines than slots, bases with high address bits set
    second_job.image_base  = 58'h2_0000_0000_0100;
    second_job.kernel_base = 58'h1_4000_0002_8000;
    second_job.dest_base   = 58'h3_0000_0000_9000;
    second_job.num_lines   = 32'd40;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // idle stretch before the first start
    repeat (4) @(posedge clk);
    run_job(first_job);
    run_job(second_job);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hw/conv_pkg.sv
hw/fetch_sequencer.sv
hw/line_store.sv
hw/lane_combiner.sv
hw/write_queue.sv
hw/conv_stream_top.sv
bench/mem_model.sv
bench/tb_conv_stream.sv

//--- Makefile
# Verilator flow for the conv_stream testbench

TOP := tb_conv_stream

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
